// ==== all.f ====
common/esp_cmd_pkg.sv
common/cmd_if.sv
spi/spi_target.sv
design/cmd_parser.sv
design/cmd_regs.sv
design/esp_cmd_top.sv
dv/esp_cmd_sva.sv
dv/tb_top.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_top
FILELIST := all.f

.PHONY: sim clean

# status comes from grep, so a missing pass line fails the target
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "sim passed"

clean:
	rm -rf obj_dir

// ==== dv/tb_top.sv ====
`timescale 1ns/100ps

module tb_top;
  import esp_cmd_pkg::*;

  localparam int KEYB_ROWS = 8;

  logic             clk;
  logic             arst_n;
  logic             sck;
  logic             cs_n;
  logic             mosi;
  logic             miso;
  logic [3:0]       conf;
  logic [LED_W-1:0] led;

  logic [31:0]      lfsr = 32'hdeef08e2;
  logic [LED_W-1:0] m_led;              // model state
  byte_t            m_keyb [KEYB_ROWS];
  logic             m_full_addr;

  esp_cmd_top #(.KEYB_ROWS(KEYB_ROWS)) u_dut (
    .clk(clk), .arst_n(arst_n), .sck(sck), .cs_n(cs_n), .mosi(mosi),
    .miso(miso), .conf(conf), .led(led)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  // hard stop if the sequence stalls
  initial begin
    repeat (100000) @(posedge clk);
    $display("watchdog expired before the test sequence finished");
    $display("sim failed");
    $fatal(1);
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
      r    = {r[30:0], b};
    end
    return r;
  endfunction

  task automatic check_equal(input string test, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %0h actual %0h", test, exp, act);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // config answer built from the model
  function automatic byte_t model_config();
    logic any;
    any = 1'b0;
    for (int r = 0; r < KEYB_ROWS; r++)
      any = any | (m_keyb[r] != 8'h00);
    return {m_full_addr, any, 2'b00, conf};
  endfunction

  // mode 0, msb first, 4 clk per half period
  task automatic spi_byte(input byte_t tx, output byte_t rx);
    for (int i = 7; i >= 0; i--) begin
      sck  = 1'b0;
      mosi = tx[i];
      repeat (4) @(negedge clk);
      rx[i] = miso;   // sampled just before rising sck
      sck   = 1'b1;
      repeat (4) @(negedge clk);
    end
  endtask

  // one cs frame of up to three bytes, rx is the last byte read back
  task automatic send_frame(input int n, input byte_t b0, input byte_t b1,
                            input byte_t b2, output byte_t rx);
    byte_t data [3];
    data[0] = b0;
    data[1] = b1;
    data[2] = b2;
    cs_n    = 1'b0;
    for (int k = 0; k < n; k++)
      spi_byte(data[k], rx);
    sck = 1'b0;
    repeat (2) @(negedge clk);
    cs_n = 1'b1;
    repeat (4) @(negedge clk);   // gap, also covers the 5 clk command latency
  endtask

  task automatic abort_frame(input byte_t tx);
    cs_n = 1'b0;
    for (int i = 7; i >= 4; i--) begin   // half a byte only
      sck  = 1'b0;
      mosi = tx[i];
      repeat (4) @(negedge clk);
      sck = 1'b1;
      repeat (4) @(negedge clk);
    end
    sck = 1'b0;
    repeat (2) @(negedge clk);
    cs_n = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  // opcode frame, then dummy frame that carries the answer
  task automatic query(input byte_t op, input string test, input byte_t exp);
    byte_t rx;
    send_frame(1, op, 8'h00, 8'h00, rx);
    send_frame(1, byte_t'(rand_bits(8)), 8'h00, 8'h00, rx);
    check_equal(test, exp, rx);
  endtask

  initial begin
    byte_t rx;
    byte_t p0;
    byte_t p1;
    byte_t op;
    arst_n      = 1'b0;
    sck         = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    conf        = 4'h0;
    m_led       = '0;
    m_full_addr = 1'b0;
    for (int r = 0; r < KEYB_ROWS; r++)
      m_keyb[r] = 8'h00;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    repeat (2) @(negedge clk);
    conf = 4'(rand_bits(4));

    check_equal("reset_led", 0, led);
    query(CMD_GET_CONFIG, "reset_config", {4'h0, conf});
    query(CMD_GET_COOKIE, "cookie", 8'haf);
    query(CMD_GET_VERSION, "version", 8'h03);

    for (int i = 0; i < 20; i++) begin
      p0 = byte_t'(rand_bits(8));
      send_frame(2, CMD_SET_LED, p0, 8'h00, rx);
      m_led = p0[2:0];
      check_equal("set_led", m_led, led);
    end

    // keyboard rows, row index wraps in the model too
    for (int i = 0; i < 12; i++) begin
      p0 = byte_t'(rand_bits(8));
      p1 = rand_bits(1) ? byte_t'(rand_bits(8)) : 8'h00;
      send_frame(3, CMD_SEND_KEYB, p0, p1, rx);
      m_keyb[p0 % KEYB_ROWS] = p1;
      query(CMD_GET_CONFIG, "keyb_any", model_config());
    end
    for (int r = 0; r < KEYB_ROWS; r++) begin
      send_frame(3, CMD_SEND_KEYB, byte_t'(r), 8'h00, rx);
      m_keyb[r] = 8'h00;
    end
    query(CMD_GET_CONFIG, "keyb_clear", {m_full_addr, 1'b0, 2'b00, conf});

    conf = 4'(rand_bits(4));
    send_frame(2, CMD_SET_FULL_ADDR, 8'h00, 8'h00, rx);
    m_full_addr = 1'b0;
    query(CMD_GET_CONFIG, "full_addr_off", model_config());
    p0 = byte_t'(rand_bits(8));
    if (p0 == 8'h00)
      p0 = 8'h01;   // must be nonzero
    send_frame(2, CMD_SET_FULL_ADDR, p0, 8'h00, rx);
    m_full_addr = 1'b1;
    query(CMD_GET_CONFIG, "full_addr_on", model_config());
    // zero again, flag has to drop from set
    send_frame(2, CMD_SET_FULL_ADDR, 8'h00, 8'h00, rx);
    m_full_addr = 1'b0;
    query(CMD_GET_CONFIG, "full_addr_clear", model_config());

    // unknown opcode leaves parser idle, next byte is a fresh opcode
    op = byte_t'(rand_bits(8)) | 8'h80;
    p0 = {5'(rand_bits(5)), ~m_led};
    send_frame(3, op, CMD_SET_LED, p0, rx);
    m_led = p0[2:0];
    check_equal("unknown_op", m_led, led);

    abort_frame(CMD_SET_LED);
    check_equal("abort_led", m_led, led);
    p0 = {5'(rand_bits(5)), ~m_led};
    send_frame(2, CMD_SET_LED, p0, 8'h00, rx);
    m_led = p0[2:0];
    check_equal("after_abort", m_led, led);

    if ((u_dut.u_parser.u_sva_parser.fail_cnt + u_dut.u_spi.u_sva_spi.fail_cnt) != 0) begin
      $display("bound assertions reported failures");
      $display("sim failed");
      $fatal(1);
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// ==== dv/esp_cmd_sva.sv ====
`timescale 1ns/100ps

module esp_cmd_sva #(
  parameter bit ON_PARSER = 1'b0   // parser side watches exec, spi side the rest
) (
  input logic clk,
  input logic arst_n,
  input logic exec,
  input logic rx_valid,
  input logic tx_active,   // answer pending or shifting
  input logic cs_n,
  input logic miso
);

  int fail_cnt = 0;   // read by the testbench at the end

  if (ON_PARSER) begin : g_parser
    a_exec_pulse: assert property (@(posedge clk) disable iff (!arst_n) exec |=> !exec)
      else begin
        fail_cnt++;
        $error("exec strobe longer than one cycle");
      end
  end else begin : g_spi
    // dummy byte of an answer frame never reaches the parser
    a_rx_quiet: assert property (@(posedge clk) disable iff (!arst_n) rx_valid |-> !tx_active)
      else begin
        fail_cnt++;
        $error("rx_valid while an answer is pending");
      end

    a_miso_idle: assert property (@(posedge clk) disable iff (!arst_n) cs_n |-> !miso)
      else begin
        fail_cnt++;
        $error("miso driven high while deselected");
      end
  end

endmodule

bind cmd_parser esp_cmd_sva #(.ON_PARSER(1'b1)) u_sva_parser (
  .clk(clk), .arst_n(arst_n), .exec(exec), .rx_valid(1'b0),
  .tx_active(1'b0), .cs_n(1'b1), .miso(1'b0)
);

bind spi_target esp_cmd_sva #(.ON_PARSER(1'b0)) u_sva_spi (
  .clk(clk), .arst_n(arst_n), .exec(1'b0), .rx_valid(rx_valid),
  .tx_active(tx_pend | tx_busy), .cs_n(cs_n), .miso(miso)
);

// ==== design/esp_cmd_top.sv ====
`timescale 1ns/100ps

module esp_cmd_top #(
  parameter int KEYB_ROWS = 8
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          sck,
  input  logic                          cs_n,
  input  logic                          mosi,
  output logic                          miso,
  input  logic [3:0]                    conf,
  output logic [esp_cmd_pkg::LED_W-1:0] led
);
  import esp_cmd_pkg::*;

  byte_t rx_byte;
  logic  rx_valid;
  logic  frame_start;
  byte_t tx_byte;    // answer from register block
  logic  tx_load;

  cmd_if cmd_bus ();   // parser -> regs

  spi_target u_spi (
    .clk         (clk),
    .arst_n      (arst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .tx_byte     (tx_byte),
    .tx_load     (tx_load)
  );

  cmd_parser u_parser (
    .clk         (clk),
    .arst_n      (arst_n),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .cmd         (cmd_bus.parser)
  );

  cmd_regs #(
    .KEYB_ROWS (KEYB_ROWS)
  ) u_regs (
    .clk     (clk),
    .arst_n  (arst_n),
    .cmd     (cmd_bus.regs),
    .conf    (conf),
    .led     (led),
    .tx_byte (tx_byte),
    .tx_load (tx_load)
  );

endmodule

// ==== design/cmd_regs.sv ====
`timescale 1ns/100ps

module cmd_regs #(
  parameter int KEYB_ROWS = 8
) (
  input  logic                          clk,
  input  logic                          arst_n,
  cmd_if.regs                           cmd,
  input  logic [3:0]                    conf,
  output logic [esp_cmd_pkg::LED_W-1:0] led,
  output esp_cmd_pkg::byte_t            tx_byte,
  output logic                          tx_load
);
  import esp_cmd_pkg::*;

  byte_t       keyb [KEYB_ROWS];   // keyboard matrix, one byte per row
  int unsigned row;
  logic        full_addr;
  logic        any_key;
  logic        answer_req;         // opcode expects an answer byte
  byte_t       answer;

  assign row = cmd.p0 % KEYB_ROWS;   // row index wraps

  // any key down anywhere in the matrix
  always_comb begin
    any_key = 1'b0;
    for (int r = 0; r < KEYB_ROWS; r++)
      any_key = any_key | (|keyb[r]);
  end

  // answer byte for query commands
  always_comb begin
    answer     = '0;
    answer_req = 1'b1;
    case (cmd.op)
      CMD_GET_COOKIE:  answer = COOKIE;
      CMD_GET_VERSION: answer = {VERSION_MAJOR, VERSION_MINOR};
      CMD_GET_CONFIG:  answer = {full_addr, any_key, 2'b00, conf};
      default:         answer_req = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      led       <= '0;
      full_addr <= 1'b0;
      tx_load   <= 1'b0;
      for (int r = 0; r < KEYB_ROWS; r++)
        keyb[r] <= '0;
    end else begin
      tx_load <= cmd.exec && answer_req;
      if (cmd.exec) begin
        case (cmd.op)
          CMD_SET_LED:       led <= cmd.p0[LED_W-1:0];   // bit0 red, bit1 green, bit2 blue
          CMD_SET_FULL_ADDR: full_addr <= |cmd.p0;
          CMD_SEND_KEYB:     keyb[row] <= cmd.p1;
          default: ;
        endcase
      end
    end
  end

  // loaded together with the tx_load pulse
  always_ff @(posedge clk) begin
    if (cmd.exec && answer_req)
      tx_byte <= answer;
  end

endmodule

// ==== design/cmd_parser.sv ====
`timescale 1ns/100ps

module cmd_parser (
  input  logic               clk,
  input  logic               arst_n,
  input  esp_cmd_pkg::byte_t rx_byte,
  input  logic               rx_valid,
  input  logic               frame_start,
  cmd_if.parser              cmd
);
  import esp_cmd_pkg::*;

  localparam int IDX_W = $clog2(MAX_PARAMS);

  typedef enum logic {
    idle,
    read_params
  } state_t;

  state_t           state;
  cmd_t             op;
  byte_t            params [MAX_PARAMS];
  param_cnt_t       left;       // parameter bytes still missing
  logic [IDX_W-1:0] idx;        // next parameter slot
  logic             exec;
  param_cnt_t       n_params;
  logic             op_known;

  // parameter count per opcode
  always_comb begin
    n_params = '0;
    op_known = 1'b1;
    case (rx_byte)
      CMD_SEND_KEYB:     n_params = 2'd2;
      CMD_SET_LED,
      CMD_SET_FULL_ADDR: n_params = 2'd1;
      CMD_GET_COOKIE,
      CMD_GET_VERSION,
      CMD_GET_CONFIG:    n_params = 2'd0;
      default:           op_known = 1'b0;   // ignored, stay idle
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= idle;
      left  <= '0;
      idx   <= '0;
      exec  <= 1'b0;
    end else begin
      exec <= 1'b0;
      if (frame_start) begin
        state <= idle;   // every cs frame starts with an opcode
      end else if (rx_valid) begin
        case (state)
          idle: begin
            if (op_known) begin
              if (n_params == '0) begin
                exec <= 1'b1;   // opcode is the whole command
              end else begin
                state <= read_params;
                left  <= n_params;
                idx   <= '0;
              end
            end
          end
          read_params: begin
            idx <= idx + 1'b1;
            if (left == 2'd1) begin
              exec  <= 1'b1;
              state <= idle;
            end else begin
              left <= left - 2'd1;
            end
          end
        endcase
      end
    end
  end

  // opcode and parameter capture
  always_ff @(posedge clk) begin
    if (rx_valid && !frame_start) begin
      if (state == idle)
        op <= rx_byte;
      else
        params[idx] <= rx_byte;
    end
  end

  assign cmd.op   = op;
  assign cmd.p0   = params[0];
  assign cmd.p1   = params[1];
  assign cmd.exec = exec;

endmodule

// ==== spi/spi_target.sv ====
`timescale 1ns/100ps

module spi_target (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               mosi,
  output logic               miso,
  output esp_cmd_pkg::byte_t rx_byte,
  output logic               rx_valid,
  output logic               frame_start,
  input  esp_cmd_pkg::byte_t tx_byte,
  input  logic               tx_load
);
  import esp_cmd_pkg::*;

  logic [2:0] sck_sync;    // [1:0] synchronizer, [2] previous value
  logic [2:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;     // bits seen in the current byte frame
  byte_t      rx_shift;
  byte_t      tx_shift;
  logic       tx_pend;     // answer loaded, frame not started yet
  logic       tx_busy;     // answer frame in progress

  // pin synchronizers, cs resets to deselected
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sck_rise    = (sck_sync[2:1] == 2'b01);
  assign sck_fall    = (sck_sync[2:1] == 2'b10);
  assign cs_active   = ~cs_sync[1];
  assign frame_start = cs_sync[2] & ~cs_sync[1];   // cs just went low

  // bit counter and receive strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;   // deselect drops a partial byte
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        rx_valid <= (bit_cnt == 3'd7) && !tx_pend && !tx_busy;   // dummy byte is swallowed
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_shift <= {rx_shift[6:0], mosi_sync[1]};   // msb first
  end

  assign rx_byte = rx_shift;

  // answer frame tracking
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_pend <= 1'b0;
      tx_busy <= 1'b0;
    end else begin
      if (tx_load)
        tx_pend <= 1'b1;
      if (!cs_active) begin
        tx_busy <= 1'b0;
      end else if (sck_rise) begin
        if (bit_cnt == 3'd0 && tx_pend) begin
          tx_pend <= 1'b0;   // first bit of the answer frame
          tx_busy <= 1'b1;
        end else if (bit_cnt == 3'd7) begin
          tx_busy <= 1'b0;   // last bit sampled by master
        end
      end
    end
  end

  // mode 0, next bit after each falling edge
  always_ff @(posedge clk) begin
    if (tx_load)
      tx_shift <= tx_byte;
    else if (tx_busy && sck_fall)
      tx_shift <= {tx_shift[6:0], 1'b0};
  end

  // raw cs_n kills miso at once on deselect
  assign miso = ~cs_n & cs_active & (tx_pend | tx_busy) & tx_shift[7];

endmodule

// ==== common/cmd_if.sv ====
`timescale 1ns/100ps

// one decoded command, parser -> register block
interface cmd_if;
  import esp_cmd_pkg::*;

  cmd_t  op;     // opcode
  byte_t p0;     // first parameter
  byte_t p1;     // second parameter
  logic  exec;   // single-cycle strobe, op/p0/p1 valid with it

  // parser side drives everything
  modport parser (
    output op,
    output p0,
    output p1,
    output exec
  );

  // register block only listens
  modport regs (
    input op,
    input p0,
    input p1,
    input exec
  );

endinterface

// ==== common/esp_cmd_pkg.sv ====
package esp_cmd_pkg;

  // one byte as it travels over the serial link
  typedef logic [7:0] byte_t;

  // opcode byte, first byte of every command
  typedef logic [7:0] cmd_t;

  // opcodes kept from the controller firmware, numbering unchanged
  localparam cmd_t CMD_GET_COOKIE    = 8'd0;
  localparam cmd_t CMD_SET_FULL_ADDR = 8'd14;   // p0 != 0 enables full addressing
  localparam cmd_t CMD_GET_VERSION   = 8'd15;
  localparam cmd_t CMD_SEND_KEYB     = 8'd19;   // p0 row, p1 column bits
  localparam cmd_t CMD_SET_LED       = 8'd26;   // p0[2:0] red/green/blue
  localparam cmd_t CMD_GET_CONFIG    = 8'd27;

  // parameter slots in the parser
  localparam int MAX_PARAMS = 2;

  // parameter bytes still to come for the current command
  typedef logic [1:0] param_cnt_t;

  // magic byte the controller probes for
  localparam byte_t COOKIE = 8'haf;

  // packs to {major, minor}
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  // rgb status led
  localparam int LED_W = 3;

endpackage
